// ==== src/open_loop_consts.svh ====
`ifndef OPEN_LOOP_CONSTS_SVH
`define OPEN_LOOP_CONSTS_SVH

// flow table and queue sizing
`define OL_MAX_FLOWS    16
`define OL_Q_LOG2       4
`define OL_NUM_FLOWS    4

// field widths
`define OL_FLOWID_W     4
`define OL_CNT_W        4
`define OL_SEQ_W        8

`endif

// ==== src/open_loop_pkg.sv ====
`include "open_loop_consts.svh"

package open_loop_pkg;

    typedef logic [`OL_FLOWID_W-1:0]    flowid_t;
    typedef logic [`OL_CNT_W-1:0]       req_cnt_t;
    typedef logic [`OL_SEQ_W-1:0]       seq_t;

    // new-flow notification as it arrives at the tile
    typedef struct packed {
        flowid_t    flowid;
        req_cnt_t   req_cnt;
    } notif_t;

    // per-flow state kept between requests
    typedef struct packed {
        req_cnt_t   remaining;
        seq_t       seq;
    } app_cntxt_t;

endpackage

// ==== src/flow_fifo.sv ====
`timescale 1ns/1ps
module flow_fifo #(
     parameter type payload_t   = logic [7:0]
    ,parameter int  LOG2_DEPTH  = 4
)(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       wr_req
    ,input  payload_t   wr_data
    ,output logic       full

    ,input  logic       rd_req
    ,output payload_t   rd_data
    ,output logic       empty
);

    localparam int DEPTH = 1 << LOG2_DEPTH;

    payload_t                   mem [DEPTH];
    logic   [LOG2_DEPTH-1:0]    wr_ptr;
    logic   [LOG2_DEPTH-1:0]    rd_ptr;
    logic   [LOG2_DEPTH:0]      count;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr = wr_req && !full;
    assign do_rd = rd_req && !empty;

    assign full  = count == (LOG2_DEPTH+1)'(DEPTH);
    assign empty = count == '0;

    // head entry is visible before the read strobe
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // producers and consumers must watch the flags
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req |-> !empty);

endmodule

// ==== src/setup_handler.sv ====
`timescale 1ns/1ps
`include "open_loop_consts.svh"
module setup_handler
import open_loop_pkg::*;
(
     input  logic           clk
    ,input  logic           rst_n

    ,input  logic           notif_q_empty
    ,input  notif_t         notif_q_data
    ,output logic           notif_q_rd_req

    ,output logic           cntxt_wr_req
    ,output flowid_t        cntxt_wr_flowid
    ,output app_cntxt_t     cntxt_wr_data

    ,output logic           send_q_wr_req
    ,output flowid_t        send_q_wr_data

    ,output logic           setup_done
);

    localparam int CNT_W = $clog2(`OL_NUM_FLOWS + 1);

    logic   [CNT_W-1:0] flows_done;
    logic               pop;

    // done once the last expected flow has been taken
    assign setup_done = flows_done == CNT_W'(`OL_NUM_FLOWS);

    assign pop            = !notif_q_empty && !setup_done;
    assign notif_q_rd_req = pop;

    // fresh context with the full count and sequence zero
    assign cntxt_wr_req              = pop;
    assign cntxt_wr_flowid           = notif_q_data.flowid;
    assign cntxt_wr_data.remaining   = notif_q_data.req_cnt;
    assign cntxt_wr_data.seq         = '0;

    // a flow with nothing to send never enters the loop
    assign send_q_wr_req  = pop && (notif_q_data.req_cnt != '0);
    assign send_q_wr_data = notif_q_data.flowid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flows_done <= '0;
        end
        else if (pop) begin
            flows_done <= flows_done + 1'b1;
        end
    end

    // a popped notification carries a known flow id and count
    a_pop_known: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !$isunknown(notif_q_data));

endmodule

// ==== src/app_cntxt_mem.sv ====
`timescale 1ns/1ps
`include "open_loop_consts.svh"
module app_cntxt_mem
import open_loop_pkg::*;
(
     input  logic           clk
    ,input  logic           rst_n

    ,input  logic           setup_done

    ,input  logic           setup_wr_req
    ,input  flowid_t        setup_wr_flowid
    ,input  app_cntxt_t     setup_wr_data

    ,input  logic           eng_rd_req
    ,input  flowid_t        eng_rd_flowid
    ,output app_cntxt_t     eng_rd_data

    ,input  logic           eng_wr_req
    ,input  flowid_t        eng_wr_flowid
    ,input  app_cntxt_t     eng_wr_data
);

    app_cntxt_t     mem [`OL_MAX_FLOWS];
    logic           wr_en;
    flowid_t        wr_flowid;
    app_cntxt_t     wr_data;

    // setup owns the write port until handover
    always_comb begin
        if (setup_done) begin
            wr_en     = eng_wr_req;
            wr_flowid = eng_wr_flowid;
            wr_data   = eng_wr_data;
        end
        else begin
            wr_en     = setup_wr_req;
            wr_flowid = setup_wr_flowid;
            wr_data   = setup_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_flowid] <= wr_data;
        end
        if (eng_rd_req) begin
            eng_rd_data <= mem[eng_rd_flowid];
        end
    end

    a_eng_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        (eng_rd_req || eng_wr_req) |-> setup_done);

endmodule

// ==== src/open_loop_tx_engine.sv ====
`timescale 1ns/1ps
module open_loop_tx_engine
import open_loop_pkg::*;
(
     input  logic           clk
    ,input  logic           rst_n

    ,input  logic           setup_done

    ,input  logic           send_q_empty
    ,input  flowid_t        send_q_rd_data
    ,output logic           send_q_rd_req

    ,output logic           send_q_wr_req
    ,output flowid_t        send_q_wr_data

    ,output logic           cntxt_rd_req
    ,output flowid_t        cntxt_rd_flowid
    ,input  app_cntxt_t     cntxt_rd_data

    ,output logic           cntxt_wr_req
    ,output flowid_t        cntxt_wr_flowid
    ,output app_cntxt_t     cntxt_wr_data

    ,output logic           req_val
    ,output flowid_t        req_flowid
    ,output seq_t           req_seq
    ,input  logic           req_rdy
);

    typedef enum logic [1:0] {
        IDLE,
        RD_WAIT,
        ISSUE
    } state_e;

    state_e         state_reg;
    state_e         state_next;
    flowid_t        cur_flowid;
    app_cntxt_t     cur_cntxt;
    app_cntxt_t     next_cntxt;
    logic           pop;
    logic           xfer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pop and context lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pop             = (state_reg == IDLE) && setup_done && !send_q_empty;
    assign send_q_rd_req   = pop;
    assign cntxt_rd_req    = pop;
    assign cntxt_rd_flowid = send_q_rd_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign req_val    = state_reg == ISSUE;
    assign req_flowid = cur_flowid;
    assign req_seq    = cur_cntxt.seq;
    assign xfer       = req_val && req_rdy;

    assign next_cntxt.remaining = cur_cntxt.remaining - 1'b1;
    assign next_cntxt.seq       = cur_cntxt.seq + 1'b1;

    assign cntxt_wr_req    = xfer;
    assign cntxt_wr_flowid = cur_flowid;
    assign cntxt_wr_data   = next_cntxt;

    // flow drops out of the rotation on its last request
    assign send_q_wr_req  = xfer && (next_cntxt.remaining != '0);
    assign send_q_wr_data = cur_flowid;

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            IDLE:    if (pop) state_next = RD_WAIT;
            RD_WAIT: state_next = ISSUE;
            ISSUE:   if (xfer) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_reg <= IDLE;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_flowid <= send_q_rd_data;
        end
        // read data lands the cycle after the pop
        if (state_reg == RD_WAIT) begin
            cur_cntxt <= cntxt_rd_data;
        end
    end

    // a flow in the send loop always has requests left
    a_cntxt_live: assert property (@(posedge clk) disable iff (!rst_n)
        (state_reg == RD_WAIT) |-> (cntxt_rd_data.remaining != '0));

endmodule

// ==== src/open_loop_app_wrap.sv ====
`timescale 1ns/1ps
`include "open_loop_consts.svh"
module open_loop_app_wrap
import open_loop_pkg::*;
(
     input  logic       clk
    ,input  logic       rst_n

    ,input  logic       notif_val
    ,input  flowid_t    notif_flowid
    ,input  req_cnt_t   notif_req_cnt
    ,output logic       notif_rdy

    ,output logic       req_val
    ,output flowid_t    req_flowid
    ,output seq_t       req_seq
    ,input  logic       req_rdy

    ,output logic       setup_done
);

    logic           notif_q_wr_req;
    notif_t         notif_q_wr_data;
    logic           notif_q_full;
    logic           notif_q_rd_req;
    notif_t         notif_q_rd_data;
    logic           notif_q_empty;

    logic           setup_cntxt_wr_req;
    flowid_t        setup_cntxt_wr_flowid;
    app_cntxt_t     setup_cntxt_wr_data;
    logic           setup_send_q_wr_req;
    flowid_t        setup_send_q_wr_data;

    logic           tx_send_q_wr_req;
    flowid_t        tx_send_q_wr_data;
    logic           send_q_wr_req;
    flowid_t        send_q_wr_data;
    logic           send_q_rd_req;
    flowid_t        send_q_rd_data;
    logic           send_q_empty;

    logic           eng_rd_req;
    flowid_t        eng_rd_flowid;
    app_cntxt_t     eng_rd_data;
    logic           eng_wr_req;
    flowid_t        eng_wr_flowid;
    app_cntxt_t     eng_wr_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // notification intake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign notif_rdy       = !notif_q_full;
    assign notif_q_wr_req  = notif_val && notif_rdy;
    assign notif_q_wr_data = '{flowid: notif_flowid, req_cnt: notif_req_cnt};

    flow_fifo #(
         .payload_t     (notif_t    )
        ,.LOG2_DEPTH    (`OL_Q_LOG2 )
    ) notif_q (
         .clk
        ,.rst_n
        ,.wr_req    (notif_q_wr_req     )
        ,.wr_data   (notif_q_wr_data    )
        ,.full      (notif_q_full       )
        ,.rd_req    (notif_q_rd_req     )
        ,.rd_data   (notif_q_rd_data    )
        ,.empty     (notif_q_empty      )
    );

    setup_handler setup (
         .clk
        ,.rst_n
        ,.notif_q_empty     (notif_q_empty          )
        ,.notif_q_data      (notif_q_rd_data        )
        ,.notif_q_rd_req    (notif_q_rd_req         )
        ,.cntxt_wr_req      (setup_cntxt_wr_req     )
        ,.cntxt_wr_flowid   (setup_cntxt_wr_flowid  )
        ,.cntxt_wr_data     (setup_cntxt_wr_data    )
        ,.send_q_wr_req     (setup_send_q_wr_req    )
        ,.send_q_wr_data    (setup_send_q_wr_data   )
        ,.setup_done
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // send loop
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (setup_done) begin
            send_q_wr_req  = tx_send_q_wr_req;
            send_q_wr_data = tx_send_q_wr_data;
        end
        else begin
            send_q_wr_req  = setup_send_q_wr_req;
            send_q_wr_data = setup_send_q_wr_data;
        end
    end

    // deep enough to hold every flow at once
    flow_fifo #(
         .payload_t     (flowid_t   )
        ,.LOG2_DEPTH    (`OL_Q_LOG2 )
    ) send_q (
         .clk
        ,.rst_n
        ,.wr_req    (send_q_wr_req  )
        ,.wr_data   (send_q_wr_data )
        ,.full      ()
        ,.rd_req    (send_q_rd_req  )
        ,.rd_data   (send_q_rd_data )
        ,.empty     (send_q_empty   )
    );

    app_cntxt_mem cntxt_mem (
         .clk
        ,.rst_n
        ,.setup_done
        ,.setup_wr_req      (setup_cntxt_wr_req     )
        ,.setup_wr_flowid   (setup_cntxt_wr_flowid  )
        ,.setup_wr_data     (setup_cntxt_wr_data    )
        ,.eng_rd_req
        ,.eng_rd_flowid
        ,.eng_rd_data
        ,.eng_wr_req
        ,.eng_wr_flowid
        ,.eng_wr_data
    );

    open_loop_tx_engine tx (
         .clk
        ,.rst_n
        ,.setup_done
        ,.send_q_empty
        ,.send_q_rd_data
        ,.send_q_rd_req
        ,.send_q_wr_req     (tx_send_q_wr_req   )
        ,.send_q_wr_data    (tx_send_q_wr_data  )
        ,.cntxt_rd_req      (eng_rd_req         )
        ,.cntxt_rd_flowid   (eng_rd_flowid      )
        ,.cntxt_rd_data     (eng_rd_data        )
        ,.cntxt_wr_req      (eng_wr_req         )
        ,.cntxt_wr_flowid   (eng_wr_flowid      )
        ,.cntxt_wr_data     (eng_wr_data        )
        ,.req_val
        ,.req_flowid
        ,.req_seq
        ,.req_rdy
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps
module tb_clk_gen (
     output logic   clk
    ,output logic   rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first ten rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== test/open_loop_tb.sv ====
`timescale 1ns/1ps
`include "open_loop_consts.svh"
module open_loop_tb
import open_loop_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       notif_val;
    flowid_t    notif_flowid;
    req_cnt_t   notif_req_cnt;
    logic       notif_rdy;
    logic       req_val;
    flowid_t    req_flowid;
    seq_t       req_seq;
    logic       req_rdy;
    logic       setup_done;

    flowid_t    notif_fid_q [$];
    req_cnt_t   notif_cnt_q [$];
    flowid_t    zero_fid_q [$];
    flowid_t    exp_fid_q [$];
    seq_t       exp_seq_q [$];

    int         value_errors = 0;
    int         other_errors = 0;
    int         reqs_seen = 0;
    int         cycles = 0;
    int         cycle_limit = 100;
    logic       load_ok = 1'b0;

    tb_clk_gen clk_gen (
         .clk
        ,.rst_n
    );

    open_loop_app_wrap i_dut (
         .clk
        ,.rst_n
        ,.notif_val
        ,.notif_flowid
        ,.notif_req_cnt
        ,.notif_rdy
        ,.req_val
        ,.req_flowid
        ,.req_seq
        ,.req_rdy
        ,.setup_done
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_flowid(input string name, input flowid_t expected, input flowid_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_seq(input string name, input seq_t expected, input seq_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pattern file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_patterns();
        int             fd;
        int             n;
        string          line;
        logic [31:0]    a;
        logic [31:0]    b;
        fd = $fopen("test/open_loop_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the pattern file test/open_loop_patterns.txt");
        end
        else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h", a, b);
                    // the first lines are notifications and the rest expected requests
                    if (n == 2 && notif_fid_q.size() < `OL_NUM_FLOWS) begin
                        notif_fid_q.push_back(flowid_t'(a));
                        notif_cnt_q.push_back(req_cnt_t'(b));
                        if (req_cnt_t'(b) == '0) begin
                            zero_fid_q.push_back(flowid_t'(a));
                        end
                    end
                    else if (n == 2) begin
                        exp_fid_q.push_back(flowid_t'(a));
                        exp_seq_q.push_back(seq_t'(b));
                    end
                end
            end
            $fclose(fd);
            load_ok = (notif_fid_q.size() == `OL_NUM_FLOWS) && (exp_fid_q.size() > 0);
            if (!load_ok) begin
                other_errors++;
                $display("pattern file holds too few notification or request lines");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_notifications();
        logic rdy_seen;
        @(posedge clk);
        #1;
        foreach (notif_fid_q[i]) begin
            notif_val     = 1'b1;
            notif_flowid  = notif_fid_q[i];
            notif_req_cnt = notif_cnt_q[i];
            rdy_seen      = 1'b0;
            while (!rdy_seen) begin
                @(negedge clk);
                rdy_seen = notif_rdy;
                check_level($sformatf("setup_done before notification %0d", i),
                    1'b0, setup_done);
                @(posedge clk);
                #1;
            end
        end
        notif_val = 1'b0;
    endtask

    task automatic run_tests();
        @(negedge clk);
        check_level("req_val after reset", 1'b0, req_val);
        check_level("setup_done after reset", 1'b0, setup_done);
        check_level("notif_rdy after reset", 1'b1, notif_rdy);
        send_notifications();
        while (!setup_done) begin
            @(negedge clk);
        end
        while (reqs_seen < exp_fid_q.size()) begin
            @(negedge clk);
        end
        repeat (50) begin
            @(negedge clk);
            check_level("req_val after last request", 1'b0, req_val);
        end
    endtask

    // random back-pressure on the request channel
    initial begin
        void'($urandom(75259));
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            req_rdy = ($urandom % 3) != 0;
        end
    end

    // outputs sampled on the falling edge
    initial begin : request_monitor
        logic       stall_prev;
        logic       done_seen;
        flowid_t    fid_prev;
        seq_t       seq_prev;
        stall_prev = 1'b0;
        done_seen  = 1'b0;
        fid_prev   = '0;
        seq_prev   = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (done_seen && !setup_done) begin
                other_errors++;
                $display("setup_done fell after it had risen");
            end
            done_seen = done_seen || setup_done;
            if (req_val && !setup_done) begin
                other_errors++;
                $display("req_val went high before setup_done");
            end
            if (stall_prev) begin
                check_level("req_val held under back-pressure", 1'b1, req_val);
                check_flowid("req_flowid held under back-pressure", fid_prev, req_flowid);
                check_seq("req_seq held under back-pressure", seq_prev, req_seq);
            end
            if (req_val) begin
                foreach (zero_fid_q[i]) begin
                    if (req_flowid == zero_fid_q[i]) begin
                        other_errors++;
                        $display("flow %h was notified with count 0 but sent a request",
                            req_flowid);
                    end
                end
            end
            if (req_val && req_rdy) begin
                if (reqs_seen < exp_fid_q.size()) begin
                    check_flowid($sformatf("request %0d flow id", reqs_seen),
                        exp_fid_q[reqs_seen], req_flowid);
                    check_seq($sformatf("request %0d sequence", reqs_seen),
                        exp_seq_q[reqs_seen], req_seq);
                end
                else begin
                    other_errors++;
                    $display("extra request beyond the expected list: flow %h sequence %h",
                        req_flowid, req_seq);
                end
                reqs_seen++;
            end
            stall_prev = req_val && !req_rdy;
            fid_prev   = req_flowid;
            seq_prev   = req_seq;
        end
    end

    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d requests seen",
            cycles, reqs_seen, exp_fid_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        notif_val     = 1'b0;
        notif_flowid  = '0;
        notif_req_cnt = '0;
        req_rdy       = 1'b0;
        load_patterns();
        cycle_limit = 100 + 20 * exp_fid_q.size();
        wait (rst_n === 1'b1);
        if (load_ok) begin
            run_tests();
        end
        $display("errors: %0d value mismatches, %0d other failures",
            value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== test/open_loop_patterns.txt ====
// notification lines first: flow id, request count (hex)
// then expected requests in order: flow id, sequence number (hex)
3 2
7 0
1 4
c 1
// expected requests
3 00
1 00
c 00
3 01
1 01
1 02
1 03

// ==== verilog.f ====
+incdir+src
src/open_loop_pkg.sv
src/flow_fifo.sv
src/setup_handler.sv
src/app_cntxt_mem.sv
src/open_loop_tx_engine.sv
src/open_loop_app_wrap.sv
test/tb_clk_gen.sv
test/open_loop_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the open-loop testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module open_loop_tb \
    && ./obj_dir/Vopen_loop_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
